// File: Makefile
TOOL  ?= verilator
FLAGS ?= --binary --timing --assert
TOP   ?= tb_hyper_phy
FLIST ?= src.f
OBJ   ?= obj_dir
PASS  := Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL) and run $(TOP)"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS)"

clean:
	rm -rf $(OBJ)

// File: hdl/cmd_addr_gen.sv
// HyperBus command/address builder
// packs direction, address space, burst type and the word address
// into the 48-bit CA word sent as three DQ words

module cmd_addr_gen (
    input  logic                  read_i,
    input  logic                  address_space_i,
    input  hyper_pkg::hyper_addr_t address_i,
    output hyper_pkg::hyper_ca_t   cmd_addr_o
);

    localparam logic LINEAR_BURST = 1'b1; // wrapped bursts not used

    always_comb begin
        cmd_addr_o = '0;
        cmd_addr_o[47] = read_i;
        cmd_addr_o[46] = address_space_i; // 1 = register space
        cmd_addr_o[45] = LINEAR_BURST;
        cmd_addr_o[44:16] = address_i[31:3]; // row and upper column
        cmd_addr_o[2:0] = address_i[2:0];    // lower column
    end

endmodule

// File: hdl/hyper_config.svh
// HyperBus PHY configuration
// latency, recovery, burst and read FIFO sizing shared by package and RTL

`ifndef HYPER_CONFIG_SVH
`define HYPER_CONFIG_SVH

// initial access latency in clock-enabled cycles
`define HYPER_WAIT_CYCLES 6

// chip select high time between transactions
`define HYPER_RWR_CYCLES 4

`define HYPER_BURST_WIDTH 12 // burst length counter width
`define HYPER_NR_CS 2

// read capture FIFO entries
`define HYPER_RX_DEPTH 4

`endif

// File: hdl/hyper_phy.sv
// HyperBus PHY top level
// word-level bus with a clock enable in place of the bus clock;
// the transaction controller drives the bus and the read capture
// FIFO returns read data

module hyper_phy (
    input  logic                    clk0,
    input  logic                    rst_ni,
    // transactions
    input  logic                    trans_valid_i,
    output logic                    trans_ready_o,
    input  hyper_pkg::hyper_addr_t  trans_address_i,
    input  hyper_pkg::hyper_cs_t    trans_cs_i,
    input  logic                    trans_write_i,
    input  hyper_pkg::hyper_burst_t trans_burst_i,
    input  logic                    trans_address_space_i,
    // write data
    input  logic                    tx_valid_i,
    output logic                    tx_ready_o,
    input  hyper_pkg::hyper_word_t  tx_data_i,
    input  hyper_pkg::hyper_strb_t  tx_strb_i,
    // read data
    output logic                    rx_valid_o,
    input  logic                    rx_ready_i,
    output hyper_pkg::hyper_word_t  rx_data_o,
    // bus
    output hyper_pkg::hyper_cs_t    hyper_cs_no,
    output logic                    hyper_ck_en_o,
    output hyper_pkg::hyper_word_t  hyper_dq_o,
    output logic                    hyper_dq_oe_o,
    output hyper_pkg::hyper_strb_t  hyper_rwds_o,
    output logic                    hyper_rwds_oe_o,
    input  hyper_pkg::hyper_word_t  hyper_dq_i,
    input  logic                    hyper_rwds_i
);

    hyper_rx_if rx_if ();

    hyper_trans_ctrl i_trans_ctrl (
        .clk0                  ( clk0                  ),
        .rst_ni                ( rst_ni                ),
        .trans_valid_i         ( trans_valid_i         ),
        .trans_ready_o         ( trans_ready_o         ),
        .trans_address_i       ( trans_address_i       ),
        .trans_cs_i            ( trans_cs_i            ),
        .trans_write_i         ( trans_write_i         ),
        .trans_burst_i         ( trans_burst_i         ),
        .trans_address_space_i ( trans_address_space_i ),
        .tx_valid_i            ( tx_valid_i            ),
        .tx_ready_o            ( tx_ready_o            ),
        .tx_data_i             ( tx_data_i             ),
        .tx_strb_i             ( tx_strb_i             ),
        .hyper_rwds_i          ( hyper_rwds_i          ),
        .hyper_cs_no           ( hyper_cs_no           ),
        .hyper_ck_en_o         ( hyper_ck_en_o         ),
        .hyper_dq_o            ( hyper_dq_o            ),
        .hyper_dq_oe_o         ( hyper_dq_oe_o         ),
        .hyper_rwds_o          ( hyper_rwds_o          ),
        .hyper_rwds_oe_o       ( hyper_rwds_oe_o       ),
        .rx                    ( rx_if                 )
    );

    hyper_read_capture i_read_capture (
        .clk0         ( clk0         ),
        .rst_ni       ( rst_ni       ),
        .hyper_dq_i   ( hyper_dq_i   ),
        .hyper_rwds_i ( hyper_rwds_i ),
        .rx           ( rx_if        ),
        .rx_valid_o   ( rx_valid_o   ),
        .rx_ready_i   ( rx_ready_i   ),
        .rx_data_o    ( rx_data_o    )
    );

endmodule

// File: hdl/hyper_pkg.sv
// HyperBus PHY types
// bus word, byte enables, addresses, command/address word, burst,
// chip selects and the controller state encoding

`include "hyper_config.svh"

package hyper_pkg;

    typedef logic [15:0] hyper_word_t; // one DQ word per clk0
    typedef logic [1:0]  hyper_strb_t; // 1 = byte written
    typedef logic [31:0] hyper_addr_t; // word address
    typedef logic [47:0] hyper_ca_t;

    typedef logic [`HYPER_BURST_WIDTH-1:0] hyper_burst_t;
    typedef logic [`HYPER_NR_CS-1:0]       hyper_cs_t;

    // transaction controller states
    typedef enum logic [2:0] {
        STANDBY,
        CMD_ADDR,
        REG_WRITE,  // config register write without latency
        LATENCY2,   // extra latency when RWDS was high
        LATENCY,
        DATA_W,
        DATA_R,
        RECOVER
    } hyper_state_e;

endpackage

// File: hdl/hyper_read_capture.sv
// HyperBus read capture
// words qualified by RWDS during the read phase go into a small FIFO,
// which drains through the rx valid/ready handshake

`include "hyper_config.svh"

module hyper_read_capture (
    input  logic                   clk0,
    input  logic                   rst_ni,
    input  hyper_pkg::hyper_word_t hyper_dq_i,
    input  logic                   hyper_rwds_i,
    hyper_rx_if.capture            rx,
    output logic                   rx_valid_o,
    input  logic                   rx_ready_i,
    output hyper_pkg::hyper_word_t rx_data_o
);
    import hyper_pkg::*;

    localparam int DEPTH = `HYPER_RX_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    hyper_word_t       mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              wr_en;
    logic              rd_en;

    assign wr_en = rx.capture_en && hyper_rwds_i; // device strobes valid words
    assign rd_en = rx_valid_o && rx_ready_i;

    assign rx_valid_o = (count != '0);
    assign rx_data_o = mem[rd_ptr];
    assign rx.empty = (count == '0);
    assign rx.almost_full = (count >= CNT_W'(DEPTH - 1));

    always_ff @(posedge clk0) begin
        if (wr_en) begin
            mem[wr_ptr] <= hyper_dq_i;
        end
    end

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else if (rx.flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
        end
    end

    // controller must stop the bus clock before the FIFO fills
    a_no_overflow : assert property (@(posedge clk0) disable iff (!rst_ni)
        wr_en |-> (count != CNT_W'(DEPTH)))
        else $error("read FIFO written while full");

endmodule

// File: hdl/hyper_rx_if.sv
// read path handshake between the transaction controller and the
// read capture FIFO

interface hyper_rx_if;

    logic capture_en;  // read data phase active
    logic flush;       // clear FIFO pointers
    logic almost_full; // one free entry or fewer
    logic empty;

    modport ctrl (
        output capture_en,
        output flush,
        input  almost_full,
        input  empty
    );

    modport capture (
        input  capture_en,
        input  flush,
        output almost_full,
        output empty
    );

endinterface

// File: hdl/hyper_trans_ctrl.sv
// HyperBus transaction controller
// takes one transaction at a time, sends the command/address, counts
// the initial latency (doubled when the device asks for it), streams
// write data or enables read capture, then holds the bus in recovery.
// back-pressure stops the bus clock enable, not the state machine

`include "hyper_config.svh"

module hyper_trans_ctrl (
    input  logic                    clk0,
    input  logic                    rst_ni,
    input  logic                    trans_valid_i,
    output logic                    trans_ready_o,
    input  hyper_pkg::hyper_addr_t  trans_address_i,
    input  hyper_pkg::hyper_cs_t    trans_cs_i,
    input  logic                    trans_write_i,
    input  hyper_pkg::hyper_burst_t trans_burst_i,
    input  logic                    trans_address_space_i,
    input  logic                    tx_valid_i,
    output logic                    tx_ready_o,
    input  hyper_pkg::hyper_word_t  tx_data_i,
    input  hyper_pkg::hyper_strb_t  tx_strb_i,
    input  logic                    hyper_rwds_i,
    output hyper_pkg::hyper_cs_t    hyper_cs_no,
    output logic                    hyper_ck_en_o,
    output hyper_pkg::hyper_word_t  hyper_dq_o,
    output logic                    hyper_dq_oe_o,
    output hyper_pkg::hyper_strb_t  hyper_rwds_o,
    output logic                    hyper_rwds_oe_o,
    hyper_rx_if.ctrl                rx
);
    import hyper_pkg::*;

    localparam int CNT_MAX = (`HYPER_WAIT_CYCLES > `HYPER_RWR_CYCLES) ?
                             `HYPER_WAIT_CYCLES : `HYPER_RWR_CYCLES;
    localparam int CNT_W = $clog2(CNT_MAX + 1);

    hyper_state_e state;

    // local copy of the accepted transaction
    hyper_addr_t  local_address;
    hyper_cs_t    local_cs;
    logic         local_write;
    hyper_burst_t local_burst;
    logic         local_address_space;

    hyper_ca_t        cmd_addr;
    hyper_word_t      ca_word;
    logic [1:0]       ca_cnt;
    logic [CNT_W-1:0] cnt;        // latency and recovery
    hyper_burst_t     burst_cnt;  // words left minus one
    logic             double_lat;
    logic             trans_accept;
    logic             cs_active;

    assign trans_ready_o = (state == STANDBY);
    assign trans_accept = trans_valid_i && trans_ready_o;

    always_ff @(posedge clk0) begin
        if (trans_accept) begin
            local_address <= trans_address_i;
            local_cs <= trans_cs_i;
            local_write <= trans_write_i;
            local_burst <= trans_burst_i;
            local_address_space <= trans_address_space_i;
        end
    end

    cmd_addr_gen i_cmd_addr_gen (
        .read_i          ( ~local_write        ),
        .address_space_i ( local_address_space ),
        .address_i       ( local_address       ),
        .cmd_addr_o      ( cmd_addr            )
    );

    // most significant word first
    assign ca_word = (ca_cnt == 2'd0) ? cmd_addr[47:32] :
                     (ca_cnt == 2'd1) ? cmd_addr[31:16] : cmd_addr[15:0];

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            state <= STANDBY;
            ca_cnt <= '0;
            cnt <= '0;
            burst_cnt <= '0;
            double_lat <= 1'b0;
        end else begin
            case (state)
                STANDBY: begin
                    ca_cnt <= '0;
                    if (trans_accept) state <= CMD_ADDR;
                end
                CMD_ADDR: begin
                    ca_cnt <= ca_cnt + 1'b1;
                    if (ca_cnt == 2'd1) double_lat <= hyper_rwds_i; // device latency request
                    if (ca_cnt == 2'd2) begin
                        cnt <= CNT_W'(`HYPER_WAIT_CYCLES - 1);
                        if (local_write && local_address_space) begin
                            state <= REG_WRITE;
                        end else begin
                            state <= double_lat ? LATENCY2 : LATENCY;
                        end
                    end
                end
                REG_WRITE: begin
                    if (tx_valid_i) begin
                        cnt <= CNT_W'(`HYPER_RWR_CYCLES - 1);
                        state <= RECOVER;
                    end
                end
                LATENCY2: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == '0) begin
                        cnt <= CNT_W'(`HYPER_WAIT_CYCLES - 1);
                        state <= LATENCY;
                    end
                end
                LATENCY: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == '0) begin
                        burst_cnt <= local_burst - 1'b1;
                        state <= local_write ? DATA_W : DATA_R;
                    end
                end
                DATA_W, DATA_R: begin
                    if (hyper_ck_en_o) begin // one word per enabled cycle
                        burst_cnt <= burst_cnt - 1'b1;
                        if (burst_cnt == '0) begin
                            cnt <= CNT_W'(`HYPER_RWR_CYCLES - 1);
                            state <= RECOVER;
                        end
                    end
                end
                RECOVER: begin
                    if (cnt != '0) begin
                        cnt <= cnt - 1'b1;
                    end else if (rx.empty) begin
                        state <= STANDBY; // wait for the reader to drain
                    end
                end
                default: state <= STANDBY;
            endcase
        end
    end

    assign cs_active = (state != STANDBY) && (state != RECOVER);
    assign hyper_cs_no = ~(local_cs & {`HYPER_NR_CS{cs_active}});

    assign rx.capture_en = (state == DATA_R);
    assign rx.flush = (state == RECOVER) && rx.empty; // realign pointers once drained

    always_comb begin
        hyper_ck_en_o = 1'b0;
        hyper_dq_o = '0;
        hyper_dq_oe_o = 1'b0;
        hyper_rwds_o = '0;
        hyper_rwds_oe_o = 1'b0;
        tx_ready_o = 1'b0;
        case (state)
            CMD_ADDR: begin
                hyper_ck_en_o = 1'b1;
                hyper_dq_oe_o = 1'b1;
                hyper_dq_o = ca_word;
            end
            REG_WRITE: begin
                hyper_ck_en_o = tx_valid_i; // no RWDS masking for registers
                hyper_dq_oe_o = 1'b1;
                hyper_dq_o = tx_data_i;
                tx_ready_o = 1'b1;
            end
            LATENCY2, LATENCY: hyper_ck_en_o = 1'b1;
            DATA_W: begin
                hyper_ck_en_o = tx_valid_i;
                hyper_dq_oe_o = 1'b1;
                hyper_dq_o = tx_data_i;
                hyper_rwds_oe_o = 1'b1;
                hyper_rwds_o = ~tx_strb_i; // high masks the byte
                tx_ready_o = 1'b1;
            end
            DATA_R: hyper_ck_en_o = !rx.almost_full;
            default: ;
        endcase
    end

    a_burst_nonzero : assert property (@(posedge clk0) disable iff (!rst_ni)
        trans_accept |-> (trans_burst_i != '0))
        else $error("transaction accepted with zero burst");

    a_cs_idle : assert property (@(posedge clk0) disable iff (!rst_ni)
        (state == STANDBY) |-> (&hyper_cs_no))
        else $error("chip select low in standby");

    // tx only drains during write phases of a write transaction
    a_tx_phase : assert property (@(posedge clk0) disable iff (!rst_ni)
        tx_ready_o |-> (state inside {REG_WRITE, DATA_W}) && local_write)
        else $error("tx_ready_o outside a write data phase");

endmodule

// File: src.f
+incdir+hdl
hdl/hyper_pkg.sv
hdl/hyper_rx_if.sv
hdl/cmd_addr_gen.sv
hdl/hyper_read_capture.sv
hdl/hyper_trans_ctrl.sv
hdl/hyper_phy.sv
test/hyper_mem_model.sv
test/tb_hyper_phy.sv

// File: test/hyper_mem_model.sv
// behavioural HyperRAM for the PHY testbench
// 64 words plus a configuration register, word-level bus with clock enable;
// decodes the command/address, asks for double latency through RWDS and
// checks that data shows up after the expected number of enabled cycles

`include "hyper_config.svh"

module hyper_mem_model (
    input  logic        clk0,
    input  logic [1:0]  hyper_cs_no,
    input  logic        hyper_ck_en_o,
    input  logic [15:0] hyper_dq_o,
    input  logic        hyper_dq_oe_o,
    input  logic [1:0]  hyper_rwds_o,
    input  logic        hyper_rwds_oe_o,
    output logic [15:0] hyper_dq_i,
    output logic        hyper_rwds_i,
    output logic        dec_valid_o,
    output logic        dec_read_o,
    output logic        dec_space_o,
    output logic [31:0] dec_addr_o
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [15:0] mem [64];
    logic [15:0] cfg = '0;        // bit 3 = double latency
    logic [15:0] ca_w [2];        // first two CA words
    logic [47:0] ca_now;
    logic [5:0]  waddr;
    logic        rd;
    logic        space;
    logic        in_data = 1'b0;
    logic        dbl_r = 1'b0;
    logic        cs_act;
    int          ca_idx = 0;
    int          lat_cnt = 0;
    int          need;
    int          wr_count = 0;    // memory words written
    int          lat_errors = 0;

    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = 16'(i * 16'h0103) ^ 16'hc000;
        end
        dec_valid_o = 1'b0;
    end

    assign cs_act = ~&hyper_cs_no;
    assign ca_now = {ca_w[0], ca_w[1], hyper_dq_o};
    assign need = dbl_r ? 2 * `HYPER_WAIT_CYCLES : `HYPER_WAIT_CYCLES;
    assign dec_read_o = rd;
    assign dec_space_o = space;
    assign hyper_dq_i = mem[waddr];
    assign hyper_rwds_i = cs_act && ((ca_idx == 1 && cfg[3]) ||
                                     (in_data && rd && hyper_ck_en_o));

    always @(posedge clk0) begin
        dec_valid_o <= 1'b0;
        if (!cs_act) begin
            ca_idx <= 0;
            lat_cnt <= 0;
            in_data <= 1'b0;
        end else if (hyper_ck_en_o) begin
            if (ca_idx < 3) begin
                if (ca_idx < 2) ca_w[ca_idx] <= hyper_dq_o;
                ca_idx <= ca_idx + 1;
                if (ca_idx == 1) dbl_r <= cfg[3]; // same value drove RWDS
                if (ca_idx == 2) begin
                    rd <= ca_now[47];
                    space <= ca_now[46];
                    dec_addr_o <= {ca_now[44:16], ca_now[2:0]};
                    waddr <= {ca_now[18:16], ca_now[2:0]};
                    in_data <= !ca_now[47] && ca_now[46]; // register write has no latency
                    dec_valid_o <= 1'b1;
                end
            end else if (!in_data) begin
                if (lat_cnt == need - 1) in_data <= 1'b1;
                else lat_cnt <= lat_cnt + 1;
            end else if (rd) begin
                waddr <= waddr + 1'b1;
            end else if (space) begin
                cfg <= hyper_dq_o;
            end else begin
                if (!hyper_rwds_o[0]) mem[waddr][7:0] <= hyper_dq_o[7:0];
                if (!hyper_rwds_o[1]) mem[waddr][15:8] <= hyper_dq_o[15:8];
                waddr <= waddr + 1'b1;
                wr_count <= wr_count + 1;
            end
        end
    end

    // no data driven by the controller before the latency ran out
    a_no_early : assert property (@(posedge clk0)
        cs_act && hyper_ck_en_o && ca_idx == 3 && !in_data |-> !hyper_dq_oe_o)
        else begin
            lat_errors++;
            $display("FAILED at %0t: write data before latency expired", $time);
        end

    // memory writes also drive RWDS as the byte mask
    a_on_time : assert property (@(posedge clk0)
        cs_act && hyper_ck_en_o && in_data && !rd |->
            hyper_dq_oe_o && (space || hyper_rwds_oe_o))
        else begin
            lat_errors++;
            $display("FAILED at %0t: write data missing at expected latency", $time);
        end

    a_read_quiet : assert property (@(posedge clk0)
        cs_act && in_data && rd |-> !hyper_dq_oe_o && !hyper_rwds_oe_o)
        else begin
            lat_errors++;
            $display("FAILED at %0t: controller drives bus during read data", $time);
        end

endmodule

// File: test/tb_hyper_phy.sv
// testbench for the HyperBus PHY
// bursts to a behavioural HyperRAM, register write for double latency,
// read back-pressure and write stalls, scoreboard against a shadow array

`include "hyper_config.svh"

module tb_hyper_phy;
    timeunit 1ns;
    timeprecision 100ps;

    logic clk0 = 1'b0;
    logic rst_ni;
    logic trans_valid_i, trans_ready_o, trans_write_i, trans_address_space_i;
    logic [31:0] trans_address_i;
    logic [1:0]  trans_cs_i;
    logic [11:0] trans_burst_i;
    logic tx_valid_i, tx_ready_o, rx_valid_o, rx_ready_i;
    logic [15:0] tx_data_i, rx_data_o;
    logic [1:0]  tx_strb_i;
    logic [1:0]  hyper_cs_no, hyper_rwds_o;
    logic [15:0] hyper_dq_o, hyper_dq_i;
    logic hyper_ck_en_o, hyper_dq_oe_o, hyper_rwds_oe_o, hyper_rwds_i;
    logic dec_valid, dec_read, dec_space;
    logic [31:0] dec_addr;

    integer      seed = 32'h2a40;
    logic [15:0] shadow [64];
    logic [15:0] exp_rd [256];  // expected rx words in order
    int          exp_wr = 0;
    int          rx_count = 0;
    int          errors = 0;
    int          timeouts = 0;
    logic [31:0] exp_addr = '0;
    logic        exp_write = 1'b0;
    logic        exp_space = 1'b0;

    always #4 clk0 = ~clk0;

    hyper_phy uut (.*);

    hyper_mem_model mem_model (
        .clk0, .hyper_cs_no, .hyper_ck_en_o, .hyper_dq_o, .hyper_dq_oe_o,
        .hyper_rwds_o, .hyper_rwds_oe_o, .hyper_dq_i, .hyper_rwds_i,
        .dec_valid_o(dec_valid), .dec_read_o(dec_read),
        .dec_space_o(dec_space), .dec_addr_o(dec_addr)
    );

    always @(posedge clk0) begin
        if (rx_valid_o && rx_ready_i) rx_count <= rx_count + 1;
    end

    task automatic fail(input string msg);
        errors++;
        $display("FAILED at %0t: %s", $time, msg);
    endtask

    task automatic timed_out(input string what);
        timeouts++;
        $display("timeout while waiting for %s at %0t ns", what, $time);
    endtask

    a_rx_data : assert property (@(posedge clk0) disable iff (!rst_ni)
        rx_valid_o && rx_ready_i |-> rx_data_o == exp_rd[rx_count % 256])
        else fail("rx word differs from shadow");

    a_no_overflow : assert property (@(posedge clk0) disable iff (!rst_ni)
        uut.rx_if.capture_en && hyper_ck_en_o |->
            uut.i_read_capture.count < `HYPER_RX_DEPTH)
        else fail("bus clocked with read FIFO full");

    a_tx_gap : assert property (@(posedge clk0) disable iff (!rst_ni)
        tx_ready_o && !tx_valid_i |-> !hyper_ck_en_o)
        else fail("bus clock running in a write gap");

    a_decode : assert property (@(posedge clk0) disable iff (!rst_ni)
        dec_valid |-> dec_addr == exp_addr && dec_read == !exp_write &&
                      dec_space == exp_space)
        else fail("decoded command/address differs from transaction");

    task automatic check_reset();
        assert (trans_ready_o && &hyper_cs_no && !hyper_ck_en_o && !hyper_dq_oe_o &&
                !hyper_rwds_oe_o && !rx_valid_o)
            else fail("outputs not at reset values");
    endtask

    task automatic wait_idle();
        int t;
        t = 0;
        while (!trans_ready_o && t < 300) begin
            @(negedge clk0);
            t++;
        end
        if (t >= 300) timed_out("the controller to return to standby");
    endtask

    task automatic send_trans(input int addr, input bit wr, input int n, input bit space);
        int t;
        exp_addr = addr;
        exp_write = wr;
        exp_space = space;
        trans_address_i = addr;
        trans_write_i = wr;
        trans_burst_i = 12'(n);
        trans_address_space_i = space;
        trans_cs_i = 2'b01;
        trans_valid_i = 1'b1;
        t = 0;
        while (!trans_ready_o && t < 100) begin
            @(negedge clk0);
            t++;
        end
        if (t >= 100) timed_out("transaction acceptance");
        @(negedge clk0);
        trans_valid_i = 1'b0;
    endtask

    task automatic write_burst(input int base, input int n, input bit gaps);
        int t;
        int a;
        int start;
        logic [15:0] d;
        logic [1:0] s;
        start = mem_model.wr_count;
        send_trans(base, 1'b1, n, 1'b0);
        for (int i = 0; i < n; i++) begin
            d = 16'($random(seed));
            s = 2'($random(seed));
            a = (base + i) % 64;
            if (gaps && $random(seed) % 2 == 0) begin // idle a cycle
                tx_valid_i = 1'b0;
                @(negedge clk0);
            end
            tx_valid_i = 1'b1;
            tx_data_i = d;
            tx_strb_i = s;
            t = 0;
            while (!tx_ready_o && t < 100) begin
                @(negedge clk0);
                t++;
            end
            if (t >= 100) timed_out("a write word to be taken");
            if (s[0]) shadow[a][7:0] = d[7:0];
            if (s[1]) shadow[a][15:8] = d[15:8];
            @(negedge clk0);
        end
        tx_valid_i = 1'b0;
        wait_idle();
        assert (mem_model.wr_count - start == n) else fail("write word count wrong");
        for (int i = 0; i < n; i++) begin
            a = (base + i) % 64;
            assert (mem_model.mem[a] == shadow[a]) else fail("memory differs from shadow");
        end
    endtask

    task automatic read_burst(input int base, input int n, input bit bp);
        int t;
        for (int i = 0; i < n; i++) begin
            exp_rd[exp_wr % 256] = shadow[(base + i) % 64];
            exp_wr++;
        end
        send_trans(base, 1'b0, n, 1'b0);
        t = 0;
        while (rx_count != exp_wr && t < 500) begin
            rx_ready_i = bp ? 1'($random(seed)) : 1'b1;
            @(negedge clk0);
            t++;
        end
        if (t >= 500) timed_out("read words");
        rx_ready_i = 1'b1;
        wait_idle();
    endtask

    initial begin
        rst_ni = 1'b0;
        trans_valid_i = 1'b0;
        trans_address_i = '0;
        trans_cs_i = '0;
        trans_write_i = 1'b0;
        trans_burst_i = '0;
        trans_address_space_i = 1'b0;
        tx_valid_i = 1'b0;
        tx_data_i = '0;
        tx_strb_i = '0;
        rx_ready_i = 1'b1;
        for (int i = 0; i < 64; i++) shadow[i] = 16'(i * 16'h0103) ^ 16'hc000;

        repeat (10) @(negedge clk0);
        check_reset();
        rst_ni = 1'b1;
        @(negedge clk0);
        check_reset();

        write_burst(8, 8, 1'b0);
        read_burst(8, 8, 1'b0);
        write_burst(20, 6, 1'b1);   // stalls on tx
        read_burst(20, 6, 1'b0);

        // config register write turns on double latency
        send_trans(0, 1'b1, 1, 1'b1);
        tx_valid_i = 1'b1;
        tx_data_i = 16'h0008;
        tx_strb_i = 2'b11;
        wait_idle();
        tx_valid_i = 1'b0;
        assert (mem_model.cfg == 16'h0008) else fail("config register not written");

        write_burst(40, 5, 1'b1);
        read_burst(8, 8, 1'b1);     // rx back-pressure
        read_burst(38, 10, 1'b1);
        assert (rx_count == exp_wr) else fail("rx word count wrong");

        $display("errors: %0d check, %0d latency, %0d timeout",
                 errors, mem_model.lat_errors, timeouts);
        if (errors + mem_model.lat_errors + timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
